// ==== dv/controllerIntegratedTb.sv ====
`include "datapath_consts.svh"

module controllerIntegratedTb;
	import datapathPkg::*;

	// 300 instructions at up to 5 cycles each, reset, then margin
	localparam int cycleLimit = 4000;

	logic CLK;
	logic arstN;
	logic [`INST_WIDTH-1:0] inst;
	logic instValid;
	logic busy;
	aluFlagsT flags;
	wbMasterT wbBus;
	logic [`DATA_WIDTH-1:0] wbDatR;
	logic wbAck;

	// shadow of the architectural state
	logic [`DATA_WIDTH-1:0] shadowRegs [`REG_COUNT];
	aluFlagsT shadowFlags;
	// bus cycle open in the model
	logic expCyc;
	// expected bus request of the current memory op
	logic [`ADDR_WIDTH-1:0] expAdr;
	logic [`DATA_WIDTH-1:0] expDat;
	logic expWe;
	// load in flight
	logic [`REG_IDX_WIDTH-1:0] loadDest;
	logic [`DATA_WIDTH-1:0] loadVal;
	// bus outputs one cycle back, for the hold checks
	wbMasterT prevWb;
	logic prevHold;

	opcodeT aluOps [7] = '{ADD, SUB, AND, OR, XOR, SHL, SHR};
	logic [31:0] rnd;
	integer seed;
	integer errCount = 0;
	integer errAtStart = 0;
	integer passCount = 0;
	integer failCount = 0;
	integer cycles = 0;

	tbClock uClock (
		.CLK  (CLK),
		.arstN(arstN)
	);

	controllerIntegrated DUT (
		.CLK      (CLK),
		.arstN    (arstN),
		.inst     (inst),
		.instValid(instValid),
		.busy     (busy),
		.flags    (flags),
		.wbOut    (wbBus),
		.wbDatR   (wbDatR),
		.wbAck    (wbAck)
	);

	tbWishboneMemory memModel (
		.CLK  (CLK),
		.arstN(arstN),
		.wbIn (wbBus),
		.datR (wbDatR),
		.ack  (wbAck)
	);

	//////////////////////////////////////////////////////////////////////
	// shadow model
	//////////////////////////////////////////////////////////////////////

	task automatic applyShadow(input logic [`INST_WIDTH-1:0] i);
		opcodeT op;
		logic [`REG_IDX_WIDTH-1:0] rd;
		logic [`DATA_WIDTH-1:0] a;
		logic [`DATA_WIDTH-1:0] b;
		logic [`DATA_WIDTH-1:0] imm5;
		logic [`DATA_WIDTH-1:0] adrSum;
		logic [`DATA_WIDTH:0] wide;
		logic [`DATA_WIDTH-1:0] res;
		logic c;
		logic f;
		logic setFlags;
		op = opcodeT'(i[17:13]);
		rd = i[12:9];
		imm5 = {{(`DATA_WIDTH - 5){i[4]}}, i[4:0]};
		a = shadowRegs[i[8:5]];
		b = (op == ADDI) ? imm5 : shadowRegs[i[3:0]];
		adrSum = a + imm5;
		wide = '0;
		res = '0;
		c = 1'b0;
		f = 1'b0;
		setFlags = 1'b1;
		case (op)
			// carry out of bit 15, ADDC adds the stored carry
			ADD, ADDC, ADDI: begin
				wide = {1'b0, a} + {1'b0, b} + {{`DATA_WIDTH{1'b0}}, (op == ADDC) && shadowFlags.c};
				res = wide[`DATA_WIDTH-1:0];
				c = wide[`DATA_WIDTH];
				f = (a[15] == b[15]) && (res[15] != a[15]);
			end
			// c means no borrow
			SUB, CMP: begin
				res = a - b;
				c = (a >= b);
				f = (a[15] != b[15]) && (res[15] != a[15]);
			end
			AND: res = a & b;
			OR: res = a | b;
			XOR: res = a ^ b;
			SHL: res = a << b[3:0];
			SHR: res = a >> b[3:0];
			MOVI: begin
				setFlags = 1'b0;
				shadowRegs[rd] = {{(`DATA_WIDTH - 9){i[8]}}, i[8:0]};
			end
			// rd gets the word at the ack edge
			LOAD: begin
				setFlags = 1'b0;
				expCyc = 1'b1;
				expAdr = adrSum[`ADDR_WIDTH-1:0];
				expWe = 1'b0;
				loadDest = rd;
				loadVal = memModel.mem[adrSum[`ADDR_WIDTH-1:0]];
			end
			STORE: begin
				setFlags = 1'b0;
				expCyc = 1'b1;
				expAdr = adrSum[`ADDR_WIDTH-1:0];
				expWe = 1'b1;
				expDat = shadowRegs[rd];
			end
			default: setFlags = 1'b0;
		endcase
		if (setFlags) begin
			shadowFlags = {c, a < b, f, res == '0, res[15]};
			if (op != CMP) begin
				shadowRegs[rd] = res;
			end
		end
	endtask

	// old value of wbAck is read here, before the edge updates it
	always @(posedge CLK) begin
		if (!arstN) begin
			for (int k = 0; k < `REG_COUNT; k++) begin
				shadowRegs[k] = '0;
			end
			shadowFlags = '0;
			expCyc = 1'b0;
		end else if (expCyc) begin
			// cycle closes on ack, a load writes rd at that edge
			if (wbAck) begin
				if (!expWe) begin
					shadowRegs[loadDest] = loadVal;
				end
				expCyc = 1'b0;
			end
		end else if (instValid) begin
			applyShadow(inst);
		end
		prevWb <= wbBus;
		prevHold <= wbBus.stb && !wbAck;
	end

	//////////////////////////////////////////////////////////////////////
	// checks, all sampled on the falling edge
	//////////////////////////////////////////////////////////////////////

	task automatic reportMismatch(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		errCount++;
		$display("mismatch at %0t: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
	endtask

	// quiet outputs while reset is low
	assert property (@(negedge CLK) !arstN |-> !busy && !wbBus.cyc && !wbBus.stb && flags == '0)
		else reportMismatch("busy,cyc,stb,flags in reset", 0,
			{24'd0, busy, wbBus.cyc, wbBus.stb, flags});

	assert property (@(negedge CLK) disable iff (!arstN) flags == shadowFlags)
		else reportMismatch("flags", {27'd0, shadowFlags}, {27'd0, flags});

	assert property (@(negedge CLK) disable iff (!arstN) wbBus.stb |-> wbBus.cyc)
		else reportMismatch("wbOut.cyc", 1, 0);

	// cycle opens after each accepted LOAD or STORE and closes after ack
	assert property (@(negedge CLK) disable iff (!arstN) wbBus.cyc == expCyc)
		else reportMismatch("wbOut.cyc", {31'd0, expCyc}, {31'd0, wbBus.cyc});

	assert property (@(negedge CLK) disable iff (!arstN) busy == wbBus.cyc)
		else reportMismatch("busy", {31'd0, wbBus.cyc}, {31'd0, busy});

	// classic cycle, request frozen until ack
	assert property (@(negedge CLK) disable iff (!arstN)
		prevHold |-> {wbBus.we, wbBus.adr, wbBus.datW} == {prevWb.we, prevWb.adr, prevWb.datW})
		else reportMismatch("wbOut.{we,adr,datW}", {prevWb.we, prevWb.adr, prevWb.datW},
			{wbBus.we, wbBus.adr, wbBus.datW});

	assert property (@(negedge CLK) disable iff (!arstN) wbBus.stb |-> wbBus.adr == expAdr)
		else reportMismatch("wbOut.adr", {17'd0, expAdr}, {17'd0, wbBus.adr});

	assert property (@(negedge CLK) disable iff (!arstN) wbBus.stb |-> wbBus.we == expWe)
		else reportMismatch("wbOut.we", {31'd0, expWe}, {31'd0, wbBus.we});

	assert property (@(negedge CLK) disable iff (!arstN)
		wbBus.stb && wbBus.we |-> wbBus.datW == expDat)
		else reportMismatch("wbOut.datW", {16'd0, expDat}, {16'd0, wbBus.datW});

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles == cycleLimit) begin
			$display("timeout: run still going after %0d cycles", cycleLimit);
			$display("TEST FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus helpers
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] drawRandom();
		return $random(seed);
	endfunction

	function automatic logic [`INST_WIDTH-1:0] regOp(input opcodeT op,
			input logic [3:0] rd, input logic [3:0] ra, input logic [3:0] rb);
		return {op, rd, ra, 1'b0, rb};
	endfunction

	function automatic logic [`INST_WIDTH-1:0] immOp(input opcodeT op,
			input logic [3:0] rd, input logic [3:0] ra, input logic [4:0] imm);
		return {op, rd, ra, imm};
	endfunction

	function automatic logic [`INST_WIDTH-1:0] moveImm(input logic [3:0] rd,
			input logic [8:0] imm);
		return {MOVI, rd, imm};
	endfunction

	// call on a falling edge, returns one falling edge after the accept
	task automatic issue(input logic [`INST_WIDTH-1:0] i);
		inst = i;
		instValid = 1'b1;
		// held while busy
		while (busy) @(negedge CLK);
		@(negedge CLK);
		instValid = 1'b0;
	endtask

	// every register to address r0 + index
	task automatic storeAll();
		for (int r = 0; r < `REG_COUNT; r++) begin
			issue(immOp(STORE, 4'(r), 4'd0, 5'(r)));
		end
	endtask

	task automatic beginTest();
		errAtStart = errCount;
	endtask

	task automatic finishTest(input string name);
		// drain the last bus cycle and its checks
		@(negedge CLK);
		while (busy) @(negedge CLK);
		@(negedge CLK);
		if (errCount == errAtStart) begin
			passCount++;
			$display("test %s: pass", name);
		end else begin
			failCount++;
			$display("test %s: fail with %0d errors", name, errCount - errAtStart);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// tests
	//////////////////////////////////////////////////////////////////////

	initial begin
		inst = '0;
		instValid = 1'b0;
		seed = 97;

		// reset values, then all registers read back as zero
		beginTest();
		wait (arstN);
		@(negedge CLK);
		storeAll();
		finishTest("reset");

		// random loads, then back-to-back ALU ops
		beginTest();
		for (int r = 0; r < `REG_COUNT; r++) begin
			rnd = drawRandom();
			issue(moveImm(4'(r), rnd[8:0]));
		end
		for (int k = 0; k < 4; k++) begin
			rnd = drawRandom();
			issue(immOp(ADDI, rnd[3:0], rnd[7:4], rnd[12:8]));
		end
		for (int k = 0; k < 60; k++) begin
			rnd = drawRandom();
			issue(regOp(aluOps[rnd[18:16] % 7], rnd[3:0], rnd[7:4], rnd[11:8]));
			if (k % 8 == 7) begin
				issue(immOp(STORE, rnd[23:20], rnd[27:24], rnd[31:27]));
			end
		end
		storeAll();
		finishTest("alu");

		// corner cases for each flag
		beginTest();
		issue(moveImm(4'd1, 9'h1FF));
		issue(moveImm(4'd2, 9'd1));
		// 0xFFFF + 1 carries to zero
		issue(regOp(ADD, 4'd3, 4'd1, 4'd2));
		issue(regOp(SHR, 4'd4, 4'd1, 4'd2));
		// 0x7FFF + 1 and 0x8000 - 1 overflow
		issue(regOp(ADD, 4'd5, 4'd4, 4'd2));
		issue(regOp(SUB, 4'd6, 4'd5, 4'd2));
		// borrow, lower unsigned
		issue(regOp(SUB, 4'd7, 4'd2, 4'd1));
		issue(regOp(CMP, 4'd0, 4'd4, 4'd4));
		issue(regOp(CMP, 4'd0, 4'd2, 4'd4));
		issue(regOp(CMP, 4'd0, 4'd1, 4'd2));
		issue(immOp(ADDI, 4'd8, 4'd1, 5'd1));
		// carry chain
		issue(regOp(ADD, 4'd9, 4'd1, 4'd1));
		issue(regOp(ADDC, 4'd10, 4'd2, 4'd2));
		issue(regOp(ADD, 4'd11, 4'd1, 4'd2));
		issue(regOp(ADDC, 4'd12, 4'd1, 4'd3));
		issue(regOp(ADDC, 4'd13, 4'd12, 4'd2));
		// logic op clears c and f
		issue(regOp(AND, 4'd14, 4'd1, 4'd5));
		for (int k = 0; k < 10; k++) begin
			rnd = drawRandom();
			issue(regOp(rnd[12] ? CMP : ADDC, rnd[3:0], rnd[7:4], rnd[11:8]));
		end
		storeAll();
		finishTest("flags");

		// load from the preloaded memory, read back by a store
		beginTest();
		for (int k = 0; k < 20; k++) begin
			rnd = drawRandom();
			issue(immOp(LOAD, rnd[3:0], rnd[7:4], rnd[12:8]));
			issue(immOp(STORE, rnd[3:0], rnd[19:16], rnd[24:20]));
		end
		storeAll();
		finishTest("load");

		// ops offered right behind bus cycles, each must run once
		beginTest();
		for (int k = 0; k < 10; k++) begin
			rnd = drawRandom();
			issue(immOp(STORE, rnd[3:0], rnd[7:4], rnd[12:8]));
			issue(regOp(ADD, rnd[3:0], rnd[3:0], rnd[3:0]));
			issue(immOp(LOAD, rnd[19:16], rnd[23:20], rnd[28:24]));
			issue(regOp(ADDC, rnd[23:20], rnd[23:20], rnd[19:16]));
		end
		storeAll();
		finishTest("stall");

		$display("tests passed %0d, failed %0d", passCount, failCount);
		if (failCount == 0 && errCount == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== dv/tbClock.sv ====
module tbClock (
	output logic CLK,
	output logic arstN
);

	// free running clock, period 10
	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	// reset held for 16 rising edges
	// released on a falling edge, away from the active edge
	initial begin
		arstN = 1'b0;
		repeat (16) @(posedge CLK);
		@(negedge CLK);
		arstN = 1'b1;
	end

endmodule

// ==== dv/tbWishboneMemory.sv ====
`include "datapath_consts.svh"

module tbWishboneMemory (
	input  logic                   CLK,
	input  logic                   arstN,
	input  datapathPkg::wbMasterT  wbIn,
	output logic [`DATA_WIDTH-1:0] datR,
	output logic                   ack
);
	import datapathPkg::*;

	// one word per bus address
	logic [`DATA_WIDTH-1:0] mem [2**`ADDR_WIDTH];
	// wait states spent and wait states wanted for this transfer
	logic [1:0] waitCnt;
	logic [1:0] delay;
	logic [31:0] fillWord;
	logic [31:0] delayWord;
	integer seed;

	// random preload of the whole array
	initial begin
		seed = 97;
		for (int i = 0; i < 2**`ADDR_WIDTH; i++) begin
			fillWord = $random(seed);
			mem[i] = fillWord[`DATA_WIDTH-1:0];
		end
	end

	// ack after 0 to 3 wait states
	assign ack = wbIn.cyc && wbIn.stb && (waitCnt == delay);
	assign datR = mem[wbIn.adr];

	always @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			delayWord = $random(seed);
			waitCnt <= '0;
			delay <= delayWord[1:0];
		end else if (ack) begin
			// new delay for the next transfer
			delayWord = $random(seed);
			waitCnt <= '0;
			delay <= delayWord[1:0];
		end else if (wbIn.stb) begin
			waitCnt <= waitCnt + 2'd1;
		end
	end

	// write lands on the ack edge
	always @(posedge CLK) begin
		if (ack && wbIn.we) begin
			mem[wbIn.adr] <= wbIn.datW;
		end
	end

endmodule

// ==== include/datapath_consts.svh ====
`ifndef DATAPATH_CONSTS_SVH
`define DATAPATH_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// datapath widths
//////////////////////////////////////////////////////////////////////

// register and bus data
`define DATA_WIDTH 16

// opcode, rd, ra, immediate or rb
`define INST_WIDTH 18

// word address on the memory bus
`define ADDR_WIDTH 15

// register file size
`define REG_COUNT 16
`define REG_IDX_WIDTH 4

`endif

// ==== run.sh ====
#!/usr/bin/env bash
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f vlog.f --top-module controllerIntegratedTb -o simv \
	&& ./obj_dir/simv | tee /dev/stderr | grep -qx "TEST OK" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// ==== source/alu.sv ====
`include "datapath_consts.svh"

module alu (
	input  logic [`DATA_WIDTH-1:0] a,
	input  logic [`DATA_WIDTH-1:0] b,
	input  datapathPkg::opcodeT    op,
	input  logic                   cIn,
	output logic [`DATA_WIDTH-1:0] y,
	output datapathPkg::aluFlagsT  flagsNext
);
	import datapathPkg::*;

	localparam int MSB = `DATA_WIDTH - 1;

	// subtract as a + ~b + 1
	logic isSub;
	logic carryIn;
	logic [`DATA_WIDTH-1:0] addB;
	// one extra bit for carry out
	logic [`DATA_WIDTH:0] sum;
	// high for ops that own c and f
	logic arith;

	//////////////////////////////////////////////////////////////////////
	// shared adder
	//////////////////////////////////////////////////////////////////////

	assign isSub = (op == SUB) || (op == CMP);
	assign addB = isSub ? ~b : b;
	// ADDC chains the stored carry
	assign carryIn = isSub | ((op == ADDC) & cIn);
	assign sum = {1'b0, a} + {1'b0, addB} + {{`DATA_WIDTH{1'b0}}, carryIn};

	//////////////////////////////////////////////////////////////////////
	// result select
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		y = '0;
		arith = 1'b0;
		case (op)
			// LOAD and STORE reuse the adder for ra + imm
			ADD, ADDC, SUB, CMP, ADDI, LOAD, STORE: begin
				y = sum[MSB:0];
				arith = 1'b1;
			end
			AND: y = a & b;
			OR: y = a | b;
			XOR: y = a ^ b;
			// shift amount is the low nibble only
			SHL: y = a << b[3:0];
			SHR: y = a >> b[3:0];
			default: y = '0;
		endcase
	end

	// carry out, for SUB this means no borrow
	assign flagsNext.c = arith & sum[`DATA_WIDTH];
	// same input signs but result sign differs
	assign flagsNext.f = arith & (a[MSB] == addB[MSB]) & (sum[MSB] != a[MSB]);
	// unsigned compare against the second operand
	assign flagsNext.l = a < b;
	assign flagsNext.z = (y == '0);
	assign flagsNext.n = y[MSB];

endmodule

// ==== source/controllerIntegrated.sv ====
`include "datapath_consts.svh"

module controllerIntegrated (
	input  logic                   CLK,
	input  logic                   arstN,
	input  logic [`INST_WIDTH-1:0] inst,
	input  logic                   instValid,
	output logic                   busy,
	output datapathPkg::aluFlagsT  flags,
	output datapathPkg::wbMasterT  wbOut,
	input  logic [`DATA_WIDTH-1:0] wbDatR,
	input  logic                   wbAck
);
	import datapathPkg::*;

	decodedInstT dec;
	aluFlagsT flagsNext;
	logic accept;
	logic setFlags;
	logic memStart;
	logic memDone;
	// load data arriving this cycle
	logic memWb;
	logic [`DATA_WIDTH-1:0] readA;
	logic [`DATA_WIDTH-1:0] readB;
	logic [`DATA_WIDTH-1:0] operandB;
	logic [`DATA_WIDTH-1:0] aluY;
	logic regWriteEn;
	logic [`REG_IDX_WIDTH-1:0] regWriteIdx;
	logic [`DATA_WIDTH-1:0] regWriteData;
	// rd of the load in flight
	logic [`REG_IDX_WIDTH-1:0] loadDest;

	//////////////////////////////////////////////////////////////////////
	// decode and operands
	//////////////////////////////////////////////////////////////////////

	instDecoder uDecoder (
		.inst(inst),
		.dec (dec)
	);

	// busy only while a bus cycle is open
	assign busy = wbOut.cyc;
	assign accept = instValid && !busy;

	regFile uRegFile (
		.CLK      (CLK),
		.arstN    (arstN),
		.readIdxA (dec.ra),
		.readIdxB (dec.rb),
		.writeIdx (regWriteIdx),
		.writeEn  (regWriteEn),
		.writeData(regWriteData),
		.readA    (readA),
		.readB    (readB)
	);

	// immediate replaces rb for ADDI and address ops
	assign operandB = dec.selectImm ? dec.imm : readB;

	alu uAlu (
		.a        (readA),
		.b        (operandB),
		.op       (dec.op),
		.cIn      (flags.c),
		.y        (aluY),
		.flagsNext(flagsNext)
	);

	//////////////////////////////////////////////////////////////////////
	// memory side
	//////////////////////////////////////////////////////////////////////

	assign memStart = accept && (dec.memRead || dec.memWrite);

	// address from the ALU sum, store data from port B
	memAccessUnit uMem (
		.CLK    (CLK),
		.arstN  (arstN),
		.start  (memStart),
		.isWrite(dec.memWrite),
		.adr    (aluY[`ADDR_WIDTH-1:0]),
		.datW   (readB),
		.wbAck  (wbAck),
		.wbOut  (wbOut),
		.done   (memDone)
	);

	always_ff @(posedge CLK) begin
		if (memStart && dec.memRead) begin
			loadDest <= dec.rd;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// write-back and flags
	//////////////////////////////////////////////////////////////////////

	// no accept while busy, so the two writers never collide
	assign memWb = memDone && !wbOut.we;
	assign regWriteEn = memWb || (accept && dec.writeReg);
	assign regWriteIdx = memWb ? loadDest : dec.rd;

	always_comb begin
		if (memWb) begin
			regWriteData = wbDatR;
		end else if (dec.op == MOVI) begin
			regWriteData = dec.imm;
		end else begin
			regWriteData = aluY;
		end
	end

	// MOVI, LOAD, STORE, NOP keep the old flags
	assign setFlags = dec.op inside {ADD, ADDC, SUB, AND, OR, XOR, SHL, SHR, CMP, ADDI};

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			flags <= '0;
		end else if (accept && setFlags) begin
			flags <= flagsNext;
		end
	end

endmodule

// ==== source/datapathPkg.sv ====
`include "datapath_consts.svh"

package datapathPkg;

	//////////////////////////////////////////////////////////////////////
	// instruction set
	//////////////////////////////////////////////////////////////////////

	// taken straight from inst[17:13], unlisted codes decode as NOP
	typedef enum logic [4:0] {
		NOP   = 5'd0,
		ADD   = 5'd1,
		ADDC  = 5'd2,
		SUB   = 5'd3,
		AND   = 5'd4,
		OR    = 5'd5,
		XOR   = 5'd6,
		SHL   = 5'd7,
		SHR   = 5'd8,
		CMP   = 5'd9,
		ADDI  = 5'd10,
		MOVI  = 5'd11,
		LOAD  = 5'd12,
		STORE = 5'd13
	} opcodeT;

	// memory access unit
	typedef enum logic {
		IDLE,
		WAIT
	} memStateT;

	// same bit order as the old FLAGS[4:0] bus
	typedef struct packed {
		logic c;
		logic l;
		logic f;
		logic z;
		logic n;
	} aluFlagsT;

	// everything the controller needs from one instruction
	typedef struct packed {
		opcodeT                    op;
		logic [`REG_IDX_WIDTH-1:0] rd;
		logic [`REG_IDX_WIDTH-1:0] ra;
		logic [`REG_IDX_WIDTH-1:0] rb;
		logic [`DATA_WIDTH-1:0]    imm;
		logic                      selectImm;
		logic                      writeReg;
		logic                      memRead;
		logic                      memWrite;
	} decodedInstT;

	// wishbone classic master outputs
	typedef struct packed {
		logic                   cyc;
		logic                   stb;
		logic                   we;
		logic [`ADDR_WIDTH-1:0] adr;
		logic [`DATA_WIDTH-1:0] datW;
	} wbMasterT;

endpackage

// ==== source/instDecoder.sv ====
`include "datapath_consts.svh"

module instDecoder (
	input  logic [`INST_WIDTH-1:0] inst,
	output datapathPkg::decodedInstT dec
);
	import datapathPkg::*;

	// raw opcode field, may hold an unused code
	opcodeT rawOp;
	// 5-bit immediate of ADDI, LOAD, STORE
	logic [`DATA_WIDTH-1:0] immShort;
	// 9-bit immediate of MOVI
	logic [`DATA_WIDTH-1:0] immLong;

	assign rawOp = opcodeT'(inst[17:13]);

	// sign extension of both formats
	assign immShort = {{(`DATA_WIDTH - 5){inst[4]}}, inst[4:0]};
	assign immLong = {{(`DATA_WIDTH - 9){inst[8]}}, inst[8:0]};

	always_comb begin
		// default is a NOP with no side effects
		dec = '0;
		dec.op = NOP;
		// register fields sit at fixed positions
		dec.rd = inst[12:9];
		dec.ra = inst[8:5];
		dec.rb = inst[3:0];
		case (rawOp)
			// register-register ops
			ADD, ADDC, SUB, AND, OR, XOR, SHL, SHR: begin
				dec.op = rawOp;
				dec.writeReg = 1'b1;
			end
			// flags only
			CMP: begin
				dec.op = rawOp;
			end
			ADDI: begin
				dec.op = rawOp;
				dec.imm = immShort;
				dec.selectImm = 1'b1;
				dec.writeReg = 1'b1;
			end
			// immediate goes straight to rd
			MOVI: begin
				dec.op = rawOp;
				dec.imm = immLong;
				dec.writeReg = 1'b1;
			end
			// address is ra + imm, rd written on ack
			LOAD: begin
				dec.op = rawOp;
				dec.imm = immShort;
				dec.selectImm = 1'b1;
				dec.memRead = 1'b1;
			end
			// store data comes out of read port B
			STORE: begin
				dec.op = rawOp;
				dec.imm = immShort;
				dec.selectImm = 1'b1;
				dec.memWrite = 1'b1;
				dec.rb = inst[12:9];
			end
			default: begin
				dec.op = NOP;
			end
		endcase
	end

endmodule

// ==== source/memAccessUnit.sv ====
`include "datapath_consts.svh"

module memAccessUnit (
	input  logic                   CLK,
	input  logic                   arstN,
	input  logic                   start,
	input  logic                   isWrite,
	input  logic [`ADDR_WIDTH-1:0] adr,
	input  logic [`DATA_WIDTH-1:0] datW,
	input  logic                   wbAck,
	output datapathPkg::wbMasterT  wbOut,
	output logic                   done
);
	import datapathPkg::*;

	memStateT state;
	logic weReg;
	// request payload, held for the whole cycle
	logic [`ADDR_WIDTH-1:0] adrReg;
	logic [`DATA_WIDTH-1:0] datWReg;

	//////////////////////////////////////////////////////////////////////
	// bus cycle FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			state <= IDLE;
			weReg <= 1'b0;
		end else begin
			case (state)
				// new request only when idle
				IDLE: begin
					if (start) begin
						state <= WAIT;
						weReg <= isWrite;
					end
				end
				// classic cycle ends on ack
				WAIT: begin
					if (wbAck) begin
						state <= IDLE;
						weReg <= 1'b0;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if ((state == IDLE) && start) begin
			adrReg <= adr;
			datWReg <= datW;
		end
	end

	// cyc and stb follow the state, one transfer per cycle
	assign wbOut.cyc = (state == WAIT);
	assign wbOut.stb = (state == WAIT);
	assign wbOut.we = weReg;
	assign wbOut.adr = adrReg;
	assign wbOut.datW = datWReg;

	// same cycle as ack, so load data can be written at that edge
	assign done = (state == WAIT) && wbAck;

endmodule

// ==== source/regFile.sv ====
`include "datapath_consts.svh"

module regFile (
	input  logic                      CLK,
	input  logic                      arstN,
	input  logic [`REG_IDX_WIDTH-1:0] readIdxA,
	input  logic [`REG_IDX_WIDTH-1:0] readIdxB,
	input  logic [`REG_IDX_WIDTH-1:0] writeIdx,
	input  logic                      writeEn,
	input  logic [`DATA_WIDTH-1:0]    writeData,
	output logic [`DATA_WIDTH-1:0]    readA,
	output logic [`DATA_WIDTH-1:0]    readB
);

	// r0 is an ordinary register, not hardwired
	logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

	// single write port, indexed directly
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn) begin
			regs[writeIdx] <= writeData;
		end
	end

	// two async read ports
	// a write shows up on the read side one cycle later
	assign readA = regs[readIdxA];
	assign readB = regs[readIdxB];

endmodule

// ==== vlog.f ====
+incdir+include
source/datapathPkg.sv
source/instDecoder.sv
source/alu.sv
source/regFile.sv
source/memAccessUnit.sv
source/controllerIntegrated.sv
dv/tbClock.sv
dv/tbWishboneMemory.sv
dv/controllerIntegratedTb.sv
